// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // core widths
    localparam int unsigned XLEN  = 32;
    localparam int unsigned ILEN  = 32;
    localparam int unsigned NREGS = 32;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // a0 is shown on the debug port
    localparam logic [4:0] REG_A0 = 5'd10;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_NOP
    } inst_class_e;

    // execute waits here for loads and stores
    typedef enum logic {
        ST_IDLE,
        ST_WAIT_MEM
    } ex_state_e;

    // current holder of the sram port
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_LSU
    } owner_e;

    typedef struct packed {
        xlen_t addr;
        xlen_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        xlen_t           pc;
        logic [ILEN-1:0] instr;
    } retire_t;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            redirect_i,
    input  xlen_t           target_i,
    input  logic            take_i,
    output logic            req_o,
    output mem_req_t        req_o_data,
    input  logic            done_i,
    input  xlen_t           rdata_i,
    output logic            instr_valid_o,
    output xlen_t           pc_o,
    output logic [ILEN-1:0] instr_o
);

    xlen_t           pc_q;
    xlen_t           addr_q;
    logic            req_q;
    logic            stale_q;
    logic            ivalid_q;
    xlen_t           ipc_q;
    logic [ILEN-1:0] instr_q;
    logic            issue;

    // start a fetch when the instruction slot is empty or being emptied
    assign issue = !req_q && !redirect_i && (!ivalid_q || take_i);
    assign req_o = req_q || issue;

    always_comb begin
        req_o_data.addr  = req_q ? addr_q : pc_q;
        req_o_data.wdata = '0;
        req_o_data.we    = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q     <= RESET_PC;
            req_q    <= 1'b0;
            stale_q  <= 1'b0;
            ivalid_q <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= target_i;
            end else if (issue) begin
                pc_q <= pc_q + 32'd4;
            end
            if (issue) begin
                req_q <= 1'b1;
            end else if (done_i) begin
                req_q <= 1'b0;
            end
            // a response still in flight belongs to the old path
            if (done_i) begin
                stale_q <= 1'b0;
            end else if (redirect_i && req_q) begin
                stale_q <= 1'b1;
            end
            if (redirect_i) begin
                ivalid_q <= 1'b0;
            end else if (done_i && !stale_q) begin
                ivalid_q <= 1'b1;
            end else if (take_i) begin
                ivalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= pc_q;
        end
        if (done_i && !stale_q) begin
            ipc_q   <= addr_q;
            instr_q <= rdata_i;
        end
    end

    assign instr_valid_o = ivalid_q;
    assign pc_o          = ipc_q;
    assign instr_o       = instr_q;

    // a response only arrives for the request still outstanding
    a_done_outstanding: assert property (@(posedge clk) disable iff (reset_i)
        done_i |-> req_q);

endmodule

`default_nettype wire

// File: logic/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  xlen_t           pc_i,
    input  logic [ILEN-1:0] instr_i,
    output logic            take_o,
    output logic            redirect_o,
    output xlen_t           target_o,
    output logic            mem_start_o,
    output mem_req_t        mem_req_o,
    input  logic            mem_done_i,
    input  xlen_t           load_data_i,
    output logic            retire_o,
    output retire_t         retire_info_o,
    output xlen_t           reg_a0_o
);

    xlen_t           rf [NREGS];
    logic            valid_q;
    xlen_t           pc_q;
    logic [ILEN-1:0] instr_q;
    ex_state_e       state_q;
    inst_class_e     cls;
    alu_op_e         alu_op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    xlen_t           imm_i;
    xlen_t           imm_s;
    xlen_t           imm_b;
    xlen_t           imm_j;
    xlen_t           rs1_val;
    xlen_t           rs2_val;
    xlen_t           alu_b;
    xlen_t           alu_res;
    xlen_t           wb_data;
    logic            is_mem;
    logic            taken;
    logic            complete;
    logic            rf_we;

    assign rd     = instr_q[11:7];
    assign funct3 = instr_q[14:12];
    assign rs1    = instr_q[19:15];
    assign rs2    = instr_q[24:20];
    assign imm_i  = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s  = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b  = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                     instr_q[11:8], 1'b0};
    assign imm_j  = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                     instr_q[30:21], 1'b0};

    // decoder, unsupported encodings fall through as nop
    always_comb begin
        cls    = CLS_NOP;
        alu_op = ALU_ADD;
        case (instr_q[6:0])
            OPC_OP: begin
                cls = CLS_ALU_REG;
                case ({instr_q[31:25], funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_010: alu_op = ALU_SLT;
                    default:         cls    = CLS_NOP;
                endcase
            end
            OPC_OPIMM:  cls = (funct3 == 3'b000) ? CLS_ALU_IMM : CLS_NOP;
            OPC_LOAD:   cls = (funct3 == 3'b010) ? CLS_LOAD : CLS_NOP;
            OPC_STORE:  cls = (funct3 == 3'b010) ? CLS_STORE : CLS_NOP;
            OPC_BRANCH: cls = (funct3[2:1] == 2'b00) ? CLS_BRANCH : CLS_NOP;
            OPC_JAL:    cls = CLS_JUMP;
            default:    cls = CLS_NOP;
        endcase
    end

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : rf[rs2];
    assign alu_b   = (cls == CLS_ALU_REG) ? rs2_val : imm_i;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rs1_val - alu_b;
            ALU_AND: alu_res = rs1_val & alu_b;
            ALU_OR:  alu_res = rs1_val | alu_b;
            ALU_XOR: alu_res = rs1_val ^ alu_b;
            ALU_SLT: alu_res = {31'd0, $signed(rs1_val) < $signed(alu_b)};
            default: alu_res = rs1_val + alu_b;
        endcase
    end

    // beq on funct3 000, bne on 001
    assign taken = (rs1_val == rs2_val) ^ funct3[0];
    assign is_mem = (cls == CLS_LOAD) || (cls == CLS_STORE);

    assign take_o      = instr_valid_i && !valid_q;
    assign redirect_o  = valid_q && (state_q == ST_IDLE)
                         && ((cls == CLS_JUMP) || ((cls == CLS_BRANCH) && taken));
    assign target_o    = pc_q + ((cls == CLS_JUMP) ? imm_j : imm_b);
    assign mem_start_o = valid_q && (state_q == ST_IDLE) && is_mem;

    always_comb begin
        mem_req_o.addr  = rs1_val + ((cls == CLS_STORE) ? imm_s : imm_i);
        mem_req_o.wdata = rs2_val;
        mem_req_o.we    = (cls == CLS_STORE);
    end

    assign complete = valid_q && (((state_q == ST_IDLE) && !is_mem)
                      || ((state_q == ST_WAIT_MEM) && mem_done_i));
    assign rf_we    = complete && (rd != 5'd0) && (cls != CLS_STORE)
                      && (cls != CLS_BRANCH) && (cls != CLS_NOP);

    always_comb begin
        case (cls)
            CLS_LOAD: wb_data = load_data_i;
            CLS_JUMP: wb_data = pc_q + 32'd4;
            default:  wb_data = alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            state_q <= ST_IDLE;
        end else begin
            if (take_o) begin
                valid_q <= 1'b1;
            end else if (complete) begin
                valid_q <= 1'b0;
            end
            if (mem_start_o) begin
                state_q <= ST_WAIT_MEM;
            end else if (mem_done_i) begin
                state_q <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_o) begin
            pc_q    <= pc_i;
            instr_q <= instr_i;
        end
        if (rf_we) begin
            rf[rd] <= wb_data;
        end
    end

    assign retire_o            = complete;
    assign retire_info_o.pc    = pc_q;
    assign retire_info_o.instr = instr_q;
    assign reg_a0_o            = rf[REG_A0];

    // a single-cycle instruction retires right after it was taken
    a_retire_after_take: assert property (@(posedge clk) disable iff (reset_i)
        retire_o && (state_q == ST_IDLE) |-> $past(take_o));

endmodule

`default_nettype wire

// File: logic/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     start_i,
    input  mem_req_t req_i,
    output logic     done_o,
    output xlen_t    data_o,
    output logic     bus_req_o,
    output mem_req_t bus_req_data_o,
    input  logic     bus_done_i,
    input  xlen_t    bus_rdata_i
);

    logic     busy_q;
    logic     done_q;
    mem_req_t req_q;
    xlen_t    data_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (bus_done_i) begin
                busy_q <= 1'b0;
            end
            done_q <= busy_q && bus_done_i;
        end
    end

    // word accesses only, low address bits dropped
    always_ff @(posedge clk) begin
        if (start_i) begin
            req_q.addr  <= {req_i.addr[XLEN-1:2], 2'b00};
            req_q.wdata <= req_i.wdata;
            req_q.we    <= req_i.we;
        end
        if (busy_q && bus_done_i) begin
            data_q <= bus_rdata_i;
        end
    end

    assign bus_req_o      = busy_q;
    assign bus_req_data_o = req_q;
    assign done_o         = done_q;
    assign data_o         = data_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> !busy_q && !done_q);

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     fetch_req_i,
    input  mem_req_t fetch_data_i,
    output logic     fetch_done_o,
    input  logic     lsu_req_i,
    input  mem_req_t lsu_data_i,
    output logic     lsu_done_o,
    output xlen_t    rdata_o,
    output xlen_t    sram_addr_o,
    output xlen_t    sram_wdata_o,
    output logic     sram_ren_o,
    output logic     sram_wen_o,
    input  xlen_t    sram_rdata_i,
    input  logic     sram_data_valid_i
);

    owner_e   owner_q;
    mem_req_t sel;
    logic     active;

    // grant only from idle, lsu first, held until data_valid
    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner_q <= OWN_NONE;
        end else if (owner_q == OWN_NONE) begin
            if (lsu_req_i) begin
                owner_q <= OWN_LSU;
            end else if (fetch_req_i) begin
                owner_q <= OWN_FETCH;
            end
        end else if (sram_data_valid_i) begin
            owner_q <= OWN_NONE;
        end
    end

    assign active = (owner_q != OWN_NONE);
    assign sel    = (owner_q == OWN_LSU) ? lsu_data_i : fetch_data_i;

    assign sram_addr_o  = sel.addr;
    assign sram_wdata_o = sel.wdata;
    assign sram_ren_o   = active && !sel.we;
    assign sram_wen_o   = active && sel.we;

    assign fetch_done_o = sram_data_valid_i && (owner_q == OWN_FETCH);
    assign lsu_done_o   = sram_data_valid_i && (owner_q == OWN_LSU);
    assign rdata_o      = sram_rdata_i;

    a_valid_has_owner: assert property (@(posedge clk) disable iff (reset_i)
        sram_data_valid_i |-> active);

    // a granted request stays on the port unchanged until data_valid
    a_port_held: assert property (@(posedge clk) disable iff (reset_i)
        active && !sram_data_valid_i |=> active && $stable(sel));

endmodule

`default_nettype wire

// File: logic/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    output xlen_t   sram_addr_o,
    output xlen_t   sram_wdata_o,
    output logic    sram_ren_o,
    output logic    sram_wen_o,
    input  xlen_t   sram_rdata_i,
    input  logic    sram_data_valid_i,
    output logic    retire_o,
    output retire_t retire_info_o,
    output xlen_t   reg_a0_o
);

    // fetch side
    logic            fetch_req;
    mem_req_t        fetch_req_data;
    logic            fetch_done;
    logic            instr_valid;
    xlen_t           instr_pc;
    logic [ILEN-1:0] instr;
    logic            take;
    logic            redirect;
    xlen_t           target;

    // load/store side
    logic            mem_start;
    mem_req_t        mem_req;
    logic            mem_done;
    xlen_t           load_data;
    logic            lsu_req;
    mem_req_t        lsu_req_data;
    logic            lsu_done;
    xlen_t           bus_rdata;

    fetch_unit fetch_u (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .target_i      (target),
        .take_i        (take),
        .req_o         (fetch_req),
        .req_o_data    (fetch_req_data),
        .done_i        (fetch_done),
        .rdata_i       (bus_rdata),
        .instr_valid_o (instr_valid),
        .pc_o          (instr_pc),
        .instr_o       (instr)
    );

    exec_stage exec_u (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid),
        .pc_i          (instr_pc),
        .instr_i       (instr),
        .take_o        (take),
        .redirect_o    (redirect),
        .target_o      (target),
        .mem_start_o   (mem_start),
        .mem_req_o     (mem_req),
        .mem_done_i    (mem_done),
        .load_data_i   (load_data),
        .retire_o      (retire_o),
        .retire_info_o (retire_info_o),
        .reg_a0_o      (reg_a0_o)
    );

    lsu lsu_u (
        .clk            (clk),
        .reset_i        (reset_i),
        .start_i        (mem_start),
        .req_i          (mem_req),
        .done_o         (mem_done),
        .data_o         (load_data),
        .bus_req_o      (lsu_req),
        .bus_req_data_o (lsu_req_data),
        .bus_done_i     (lsu_done),
        .bus_rdata_i    (bus_rdata)
    );

    mem_arbiter arb_u (
        .clk               (clk),
        .reset_i           (reset_i),
        .fetch_req_i       (fetch_req),
        .fetch_data_i      (fetch_req_data),
        .fetch_done_o      (fetch_done),
        .lsu_req_i         (lsu_req),
        .lsu_data_i        (lsu_req_data),
        .lsu_done_o        (lsu_done),
        .rdata_o           (bus_rdata),
        .sram_addr_o       (sram_addr_o),
        .sram_wdata_o      (sram_wdata_o),
        .sram_ren_o        (sram_ren_o),
        .sram_wen_o        (sram_wen_o),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i)
    );

endmodule

`default_nettype wire

// File: testbench/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top
    import core_pkg::*;
();

    localparam int MEM_WORDS      = 256;
    localparam int RETIRE_TIMEOUT = 100;
    localparam logic [31:0] SEED  = 32'he2085025;
    // custom-0 major opcode, decodes as a nop
    localparam logic [6:0] OPC_CUSTOM = 7'b0001011;

    logic    clk;
    logic    reset_i;
    xlen_t   sram_addr_o;
    xlen_t   sram_wdata_o;
    logic    sram_ren_o;
    logic    sram_wen_o;
    xlen_t   sram_rdata_i;
    logic    sram_data_valid_i;
    logic    retire_o;
    retire_t retire_info_o;
    xlen_t   reg_a0_o;

    xlen_t       mem [MEM_WORDS];
    logic [31:0] prog_q [$];
    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;

    // sram model state
    logic  busy;
    xlen_t req_addr;
    int    lat;
    logic  b0;
    logic  b1;

    core_top uut (
        .clk               (clk),
        .reset_i           (reset_i),
        .sram_addr_o       (sram_addr_o),
        .sram_wdata_o      (sram_wdata_o),
        .sram_ren_o        (sram_ren_o),
        .sram_wen_o        (sram_wen_o),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .retire_o          (retire_o),
        .retire_info_o     (retire_info_o),
        .reg_a0_o          (reg_a0_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr, taps 32 31 29 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic draw_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
        return b;
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input int imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input int imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // sram answers after 1 to 4 cycles, one request at a time
    always @(negedge clk) begin
        if (sram_data_valid_i) begin
            sram_data_valid_i = 1'b0;
            busy = 1'b0;
        end else if (!(sram_ren_o || sram_wen_o)) begin
            busy = 1'b0;
        end else begin
            if (!busy) begin
                busy = 1'b1;
                req_addr = sram_addr_o;
                if (sram_addr_o[1:0] !== 2'b00) begin
                    other_errors++;
                    $display("sram address not word aligned at time %0t", $time);
                end
                b0 = draw_bit();
                b1 = draw_bit();
                lat = 1 + int'({b1, b0});
            end else if (sram_addr_o !== req_addr) begin
                other_errors++;
                $display("sram address changed before data_valid at time %0t", $time);
            end
            lat--;
            if (lat == 0) begin
                if (sram_wen_o) begin
                    mem[sram_addr_o[9:2]] = sram_wdata_o;
                end else begin
                    sram_rdata_i = mem[sram_addr_o[9:2]];
                end
                sram_data_valid_i = 1'b1;
            end
        end
    end

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_retire(input string name, input retire_t got, input retire_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail %0t %s got pc %h instr %h expected pc %h instr %h",
                     $time, name, got.pc, got.instr, exp.pc, exp.instr);
        end
    endtask

    // fill memory, place the program at 0 and hold reset for 5 cycles
    task automatic start_program();
        int i;
        @(negedge clk);
        reset_i = 1'b1;
        @(negedge clk);
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[24:0], OPC_CUSTOM};
        end
        for (i = 0; i < prog_q.size(); i++) begin
            mem[i] = prog_q[i];
        end
        repeat (3) @(negedge clk);
        if (sram_ren_o || sram_wen_o || retire_o) begin
            other_errors++;
            $display("sram enable or retire high during reset at time %0t", $time);
        end
        @(negedge clk);
        reset_i = 1'b0;
    endtask

    // a0 is read one cycle after the retire edge
    task automatic next_retire(output retire_t info, output xlen_t a0, output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        info = '0;
        a0 = '0;
        while (!ok && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (retire_o === 1'b1) begin
                ok = 1'b1;
                info = retire_info_o;
            end
        end
        if (ok) begin
            @(negedge clk);
            a0 = reg_a0_o;
        end else begin
            other_errors++;
            $display("no instruction retired within %0d cycles at time %0t",
                     RETIRE_TIMEOUT, $time);
        end
    endtask

    task automatic expect_retire(input xlen_t pc, output xlen_t a0);
        retire_t got;
        retire_t exp;
        logic    ok;
        next_retire(got, a0, ok);
        if (ok) begin
            exp.pc = pc;
            exp.instr = prog_q[pc[31:2]];
            check_retire("retire_info_o", got, exp);
        end
    endtask

    task automatic alu_chain();
        xlen_t r1, r2, r3, r4, r5, r6, r7, r8;
        xlen_t a0;
        int    i;
        prog_q.delete();
        prog_q.push_back(i_type(OPC_OPIMM, 5'd1, 3'b000, 5'd0, 13));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd2, 3'b000, 5'd0, -6));
        prog_q.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog_q.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog_q.push_back(r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd5));
        prog_q.push_back(r_type(7'h00, 5'd2, 5'd4, 3'b110, 5'd6));
        prog_q.push_back(r_type(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));
        prog_q.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        prog_q.push_back(r_type(7'h00, 5'd8, 5'd7, 3'b000, 5'd10));
        r1 = 13;
        r2 = -6;
        r3 = r1 + r2;
        r4 = r1 - r2;
        r5 = r3 & r4;
        r6 = r4 | r2;
        r7 = r6 ^ r5;
        r8 = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
        start_program();
        for (i = 0; i < prog_q.size(); i++) begin
            expect_retire(4 * i, a0);
        end
        check_word("reg_a0_o", a0, r7 + r8);
    endtask

    task automatic store_load();
        xlen_t a0;
        xlen_t word;
        int    i;
        word = -1234;
        prog_q.delete();
        prog_q.push_back(i_type(OPC_OPIMM, 5'd1, 3'b000, 5'd0, 'h200));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd2, 3'b000, 5'd0, -1234));
        // offset 5 lands on the word at 0x204
        prog_q.push_back(s_type(5'd2, 5'd1, 5));
        prog_q.push_back(i_type(OPC_LOAD, 5'd10, 3'b010, 5'd1, 4));
        start_program();
        for (i = 0; i < prog_q.size(); i++) begin
            expect_retire(4 * i, a0);
        end
        check_word("reg_a0_o", a0, word);
        check_word("mem[0x204]", mem['h204 >> 2], word);
    endtask

    task automatic branches();
        xlen_t a0;
        prog_q.delete();
        prog_q.push_back(i_type(OPC_OPIMM, 5'd1, 3'b000, 5'd0, 7));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd2, 3'b000, 5'd0, 7));
        prog_q.push_back(b_type(3'b000, 5'd1, 5'd2, 12));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 99));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 98));
        prog_q.push_back(b_type(3'b001, 5'd1, 5'd2, 12));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd1, 5));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd10, 1));
        start_program();
        expect_retire(0, a0);
        expect_retire(4, a0);
        expect_retire(8, a0);
        // taken beq skips 12 and 16
        expect_retire(8 + 12, a0);
        expect_retire(24, a0);
        expect_retire(28, a0);
        check_word("reg_a0_o", a0, 7 + 5 + 1);
    endtask

    task automatic jump_link();
        xlen_t a0;
        prog_q.delete();
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 1));
        prog_q.push_back(j_type(5'd10, 12));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 55));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 66));
        prog_q.push_back(r_type(7'h00, 5'd10, 5'd10, 3'b000, 5'd10));
        start_program();
        expect_retire(0, a0);
        expect_retire(4, a0);
        check_word("reg_a0_o", a0, 4 + 4);
        expect_retire(4 + 12, a0);
        check_word("reg_a0_o", a0, 2 * (4 + 4));
    endtask

    task automatic x0_and_nop();
        xlen_t a0;
        prog_q.delete();
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 77));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd0, 3'b000, 5'd0, 123));
        prog_q.push_back(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd10));
        prog_q.push_back(i_type(OPC_OPIMM, 5'd10, 3'b000, 5'd0, 42));
        prog_q.push_back(i_type(OPC_CUSTOM, 5'd10, 3'b000, 5'd10, 1));
        start_program();
        expect_retire(0, a0);
        check_word("reg_a0_o", a0, 77);
        expect_retire(4, a0);
        expect_retire(8, a0);
        check_word("reg_a0_o", a0, 0);
        expect_retire(12, a0);
        expect_retire(16, a0);
        check_word("reg_a0_o", a0, 42);
    endtask

    initial begin
        reset_i = 1'b1;
        sram_rdata_i = '0;
        sram_data_valid_i = 1'b0;
        busy = 1'b0;
        lat = 0;
        lfsr = SEED;
        value_errors = 0;
        other_errors = 0;
        alu_chain();
        store_load();
        branches();
        jump_link();
        x0_and_nop();
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/core_pkg.sv
logic/fetch_unit.sv
logic/exec_stage.sv
logic/lsu.sv
logic/mem_arbiter.sv
logic/core_top.sv
testbench/tb_core_top.sv

// File: Bender.yml
package:
  name: core_top

sources:
  - logic/core_pkg.sv
  - logic/fetch_unit.sv
  - logic/exec_stage.sv
  - logic/lsu.sv
  - logic/mem_arbiter.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - testbench/tb_core_top.sv
